//--- list.f
+incdir+source
source/robot_nav_pkg.sv
source/pixel_classifier.sv
source/sighting_buffer.sv
source/sensor_filter.sv
source/direction_fsm.sv
source/robot_nav_top.sv
tests/robot_nav_asserts.sv
tests/robot_nav_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module robot_nav_tb -f list.f -o robot_nav_sim

# the log decides the verdict, not the exit status of the simulator
./obj_dir/robot_nav_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "tests failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if grep -q "%Error" sim.log || ! grep -qx "all tests passed" sim.log; then
	echo "simulation stopped before the verdict"
	exit 1
fi
exit 0

//--- source/direction_fsm.sv
// direction_fsm module: round-trip state machine with turn timeout and drive hold timers
`include "robot_nav_cfg.svh"

module direction_fsm (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      red_seen,
	input  logic                      green_seen,
	input  logic                      blue_seen,
	input  logic                      too_close,
	input  logic                      loud,
	output robot_nav_pkg::nav_state_t direction
);

	localparam int TURN_W = $clog2(`TURN_TIMEOUT + 1);
	localparam int HOLD_W = $clog2(`DRIVE_HOLD + 1);

	robot_nav_pkg::nav_state_t state;
	robot_nav_pkg::nav_state_t next_state;
	logic [TURN_W-1:0] turn_cnt;
	logic [HOLD_W-1:0] hold_cnt;
	logic in_turn;
	logic in_drive;
	logic turn_done;
	logic hold_done;

	assign in_turn = (state == robot_nav_pkg::TURN) || (state == robot_nav_pkg::TURN_BACK);
	assign in_drive = (state == robot_nav_pkg::FORWARDS) ||
		(state == robot_nav_pkg::TO_TABLE) ||
		(state == robot_nav_pkg::BACKWARDS);

	assign turn_done = (turn_cnt == TURN_W'(`TURN_TIMEOUT));
	assign hold_done = (hold_cnt == HOLD_W'(`DRIVE_HOLD));

	// turn timer is zero whenever the robot is outside a turn,
	// so it restarts on each entry into TURN or TURN_BACK
	always_ff @(posedge clk) begin
		if (rst || !in_turn) begin
			turn_cnt <= '0;
		end else if (!turn_done) begin
			turn_cnt <= turn_cnt + 1'b1;
		end
	end

	// drive hold keeps the robot from stopping right after it sets off
	always_ff @(posedge clk) begin
		if (rst || !in_drive) begin
			hold_cnt <= '0;
		end else if (!hold_done) begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			robot_nav_pkg::IDLE_BASE: begin
				if (loud) begin
					next_state = robot_nav_pkg::FORWARDS;
				end
			end
			robot_nav_pkg::FORWARDS: begin
				// blue marks the bay entrance
				if (blue_seen) begin
					next_state = robot_nav_pkg::TURN;
				end
			end
			robot_nav_pkg::TURN: begin
				if (green_seen || turn_done) begin
					next_state = robot_nav_pkg::TO_TABLE;
				end
			end
			robot_nav_pkg::TO_TABLE: begin
				// red marks the table, a wall also stops us once the hold is over
				if (red_seen || (too_close && hold_done)) begin
					next_state = robot_nav_pkg::IDLE_TABLE;
				end
			end
			robot_nav_pkg::IDLE_TABLE: begin
				if (loud) begin
					next_state = robot_nav_pkg::BACKWARDS;
				end
			end
			robot_nav_pkg::BACKWARDS: begin
				if (green_seen) begin
					next_state = robot_nav_pkg::TURN_BACK;
				end
			end
			robot_nav_pkg::TURN_BACK: begin
				if (blue_seen || turn_done) begin
					next_state = robot_nav_pkg::RETURN_HOME;
				end
			end
			robot_nav_pkg::RETURN_HOME: begin
				// no hold on the way home
				if (red_seen || too_close) begin
					next_state = robot_nav_pkg::IDLE_BASE;
				end
			end
			default: begin
				next_state = robot_nav_pkg::IDLE_BASE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= robot_nav_pkg::IDLE_BASE;
		end else begin
			state <= next_state;
		end
	end

	assign direction = state;

endmodule

//--- source/pixel_classifier.sv
// pixel_classifier module: per-pixel colour decision and per-frame colour counts
`include "robot_nav_cfg.svh"

module pixel_classifier (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pix_valid,
	input  logic [`CHAN_W-1:0]    pix_r,
	input  logic [`CHAN_W-1:0]    pix_g,
	input  logic [`CHAN_W-1:0]    pix_b,
	input  logic                  frame_end,
	output logic                  counts_valid,
	output logic [`PIX_CNT_W-1:0] red_count,
	output logic [`PIX_CNT_W-1:0] green_count,
	output logic [`PIX_CNT_W-1:0] blue_count
);

	robot_nav_pkg::pixel_color_t pix_color;
	logic hit_r;
	logic hit_g;
	logic hit_b;
	logic [`PIX_CNT_W-1:0] red_acc;
	logic [`PIX_CNT_W-1:0] green_acc;
	logic [`PIX_CNT_W-1:0] blue_acc;
	logic [`PIX_CNT_W-1:0] red_next;
	logic [`PIX_CNT_W-1:0] green_next;
	logic [`PIX_CNT_W-1:0] blue_next;

	// a channel wins only if bright enough and strictly above the other two,
	// so at most one branch can match
	always_comb begin
		if (pix_r >= `CHAN_W'(`COLOR_MIN) && pix_r > pix_g && pix_r > pix_b) begin
			pix_color = robot_nav_pkg::COLOR_RED;
		end else if (pix_g >= `CHAN_W'(`COLOR_MIN) && pix_g > pix_r && pix_g > pix_b) begin
			pix_color = robot_nav_pkg::COLOR_GREEN;
		end else if (pix_b >= `CHAN_W'(`COLOR_MIN) && pix_b > pix_r && pix_b > pix_g) begin
			pix_color = robot_nav_pkg::COLOR_BLUE;
		end else begin
			pix_color = robot_nav_pkg::COLOR_NONE;
		end
	end

	assign hit_r = pix_valid && (pix_color == robot_nav_pkg::COLOR_RED);
	assign hit_g = pix_valid && (pix_color == robot_nav_pkg::COLOR_GREEN);
	assign hit_b = pix_valid && (pix_color == robot_nav_pkg::COLOR_BLUE);

	// running totals including the pixel of this cycle
	assign red_next = red_acc + `PIX_CNT_W'(hit_r);
	assign green_next = green_acc + `PIX_CNT_W'(hit_g);
	assign blue_next = blue_acc + `PIX_CNT_W'(hit_b);

	always_ff @(posedge clk) begin
		if (rst) begin
			counts_valid <= 1'b0;
			red_acc <= '0;
			green_acc <= '0;
			blue_acc <= '0;
		end else if (frame_end) begin
			// next frame starts from zero
			counts_valid <= 1'b1;
			red_acc <= '0;
			green_acc <= '0;
			blue_acc <= '0;
		end else begin
			counts_valid <= 1'b0;
			red_acc <= red_next;
			green_acc <= green_next;
			blue_acc <= blue_next;
		end
	end

	// closing pixel still belongs to this frame
	always_ff @(posedge clk) begin
		if (frame_end) begin
			red_count <= red_next;
			green_count <= green_next;
			blue_count <= blue_next;
		end
	end

endmodule

//--- source/robot_nav_cfg.svh
// widths, distance limit, microphone window depth and controller timer lengths
`ifndef ROBOT_NAV_CFG_SVH
`define ROBOT_NAV_CFG_SVH

// camera pixel channels and per-frame counts
`define CHAN_W 8
`define PIX_CNT_W 17
// a channel below this is too dark to call a colour
`define COLOR_MIN 64

// ultrasonic distance
`define DIST_W 8
`define TOO_CLOSE 30

// microphone level and window length
`define MIC_W 10
`define MIC_DEPTH 4

// controller timers in clock cycles, short enough for simulation
`define TURN_TIMEOUT 200
`define DRIVE_HOLD 100

`endif

//--- source/robot_nav_pkg.sv
// robot_nav_pkg package: trip state and pixel colour types
package robot_nav_pkg;

	// trip states, in the order the robot walks them
	// IDLE_BASE is zero so a cleared register lands at the base
	typedef enum logic [3:0] {
		IDLE_BASE   = 4'd0,
		FORWARDS    = 4'd1,
		TURN        = 4'd2,
		TO_TABLE    = 4'd3,
		IDLE_TABLE  = 4'd4,
		BACKWARDS   = 4'd5,
		TURN_BACK   = 4'd6,
		RETURN_HOME = 4'd7
	} nav_state_t;

	// dominant colour of one pixel
	typedef enum logic [1:0] {
		COLOR_NONE  = 2'd0,
		COLOR_RED   = 2'd1,
		COLOR_GREEN = 2'd2,
		COLOR_BLUE  = 2'd3
	} pixel_color_t;

endpackage

//--- source/robot_nav_top.sv
// robot_nav_top module: classifier, sighting buffer, sensor filter and direction controller
`include "robot_nav_cfg.svh"

module robot_nav_top (
	input  logic                      clk,
	input  logic                      rst,
	// camera stream
	input  logic                      pix_valid,
	input  logic [`CHAN_W-1:0]        pix_r,
	input  logic [`CHAN_W-1:0]        pix_g,
	input  logic [`CHAN_W-1:0]        pix_b,
	input  logic                      frame_end,
	input  logic [`PIX_CNT_W-1:0]     threshold_pixels,
	// ultrasonic and microphone
	input  logic                      dist_valid,
	input  logic [`DIST_W-1:0]        distance,
	input  logic                      mic_valid,
	input  logic [`MIC_W-1:0]         mic_level,
	input  logic [`MIC_W-1:0]         threshold_level,
	output robot_nav_pkg::nav_state_t direction,
	output logic                      red_seen,
	output logic                      green_seen,
	output logic                      blue_seen
);

	logic counts_valid;
	logic [`PIX_CNT_W-1:0] red_count;
	logic [`PIX_CNT_W-1:0] green_count;
	logic [`PIX_CNT_W-1:0] blue_count;
	logic too_close;
	logic loud;

	pixel_classifier classifier0 (
		.clk          (clk),
		.rst          (rst),
		.pix_valid    (pix_valid),
		.pix_r        (pix_r),
		.pix_g        (pix_g),
		.pix_b        (pix_b),
		.frame_end    (frame_end),
		.counts_valid (counts_valid),
		.red_count    (red_count),
		.green_count  (green_count),
		.blue_count   (blue_count)
	);

	sighting_buffer buffer0 (
		.clk              (clk),
		.rst              (rst),
		.counts_valid     (counts_valid),
		.red_count        (red_count),
		.green_count      (green_count),
		.blue_count       (blue_count),
		.threshold_pixels (threshold_pixels),
		.red_seen         (red_seen),
		.green_seen       (green_seen),
		.blue_seen        (blue_seen)
	);

	sensor_filter filter0 (
		.clk             (clk),
		.rst             (rst),
		.dist_valid      (dist_valid),
		.distance        (distance),
		.mic_valid       (mic_valid),
		.mic_level       (mic_level),
		.threshold_level (threshold_level),
		.too_close       (too_close),
		.loud            (loud)
	);

	direction_fsm fsm0 (
		.clk        (clk),
		.rst        (rst),
		.red_seen   (red_seen),
		.green_seen (green_seen),
		.blue_seen  (blue_seen),
		.too_close  (too_close),
		.loud       (loud),
		.direction  (direction)
	);

endmodule

//--- source/sensor_filter.sv
// sensor_filter module: two-sample distance check and microphone threshold window
`include "robot_nav_cfg.svh"

module sensor_filter (
	input  logic              clk,
	input  logic              rst,
	input  logic              dist_valid,
	input  logic [`DIST_W-1:0] distance,
	input  logic              mic_valid,
	input  logic [`MIC_W-1:0] mic_level,
	input  logic [`MIC_W-1:0] threshold_level,
	output logic              too_close,
	output logic              loud
);

	// index 0 holds the newest sample
	logic [`DIST_W-1:0] dist_hist [2];
	logic [`MIC_W-1:0] mic_win [`MIC_DEPTH];

	// history starts at the far end of the range so nothing looks close
	always_ff @(posedge clk) begin
		if (rst) begin
			dist_hist[0] <= '1;
			dist_hist[1] <= '1;
		end else if (dist_valid) begin
			dist_hist[1] <= dist_hist[0];
			dist_hist[0] <= distance;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MIC_DEPTH; i++) begin
				mic_win[i] <= '0;
			end
		end else if (mic_valid) begin
			mic_win[0] <= mic_level;
			for (int i = 1; i < `MIC_DEPTH; i++) begin
				mic_win[i] <= mic_win[i-1];
			end
		end
	end

	// both samples must agree, one short echo is not an obstacle
	assign too_close = (dist_hist[0] <= `DIST_W'(`TOO_CLOSE)) &&
		(dist_hist[1] <= `DIST_W'(`TOO_CLOSE));

	// whole window has to be loud, a single spike is rejected
	always_comb begin
		loud = 1'b1;
		for (int i = 0; i < `MIC_DEPTH; i++) begin
			if (mic_win[i] < threshold_level) begin
				loud = 1'b0;
			end
		end
	end

endmodule

//--- source/sighting_buffer.sv
// sighting_buffer module: per-frame colour flags from counts against the pixel threshold
`include "robot_nav_cfg.svh"

module sighting_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  counts_valid,
	input  logic [`PIX_CNT_W-1:0] red_count,
	input  logic [`PIX_CNT_W-1:0] green_count,
	input  logic [`PIX_CNT_W-1:0] blue_count,
	input  logic [`PIX_CNT_W-1:0] threshold_pixels,
	output logic                  red_seen,
	output logic                  green_seen,
	output logic                  blue_seen
);

	// flags only move on a finished frame and hold until the next one,
	// so a threshold change mid-frame has no effect until then
	always_ff @(posedge clk) begin
		if (rst) begin
			red_seen <= 1'b0;
			green_seen <= 1'b0;
			blue_seen <= 1'b0;
		end else if (counts_valid) begin
			// strictly above, a count equal to the threshold is no sighting
			red_seen <= (red_count > threshold_pixels);
			green_seen <= (green_count > threshold_pixels);
			blue_seen <= (blue_count > threshold_pixels);
		end
	end

endmodule

//--- tests/robot_nav_asserts.sv
// robot_nav_asserts module: direction encoding, counts_valid pulse and flag update checks
module robot_nav_asserts (
	input logic                      clk,
	input logic                      rst,
	input logic                      counts_valid,
	input robot_nav_pkg::nav_state_t direction,
	input logic                      red_seen,
	input logic                      green_seen,
	input logic                      blue_seen
);

	// codes above RETURN_HOME are outside the enum
	dir_legal: assert property (@(posedge clk) disable iff (rst)
		direction <= robot_nav_pkg::RETURN_HOME)
		else $error("direction holds an illegal state code");

	// one pulse per frame
	counts_pulse: assert property (@(posedge clk) disable iff (rst)
		counts_valid |=> !counts_valid)
		else $error("counts_valid high for two cycles in a row");

	// the buffer only moves on a finished frame
	flags_hold: assert property (@(posedge clk) disable iff (rst)
		$changed({red_seen, green_seen, blue_seen}) |-> $past(counts_valid))
		else $error("colour flags changed without counts_valid");

endmodule

bind robot_nav_top robot_nav_asserts asserts0 (
	.clk          (clk),
	.rst          (rst),
	.counts_valid (counts_valid),
	.direction    (direction),
	.red_seen     (red_seen),
	.green_seen   (green_seen),
	.blue_seen    (blue_seen)
);

//--- tests/robot_nav_tb.sv
// robot_nav_tb module: clock, reset, colour reference model, directed tests, watchdog and verdict
`include "robot_nav_cfg.svh"

module robot_nav_tb;

	localparam int PIX_TH = 6;
	localparam logic [`MIC_W-1:0] MIC_TH = 10'd500;
	// generous bound on the whole run in clock cycles
	localparam int RUN_CYCLES = 16 * 60 + 3 * (`TURN_TIMEOUT + `DRIVE_HOLD) + 1500;

	logic clk;
	logic rst;
	logic pix_valid;
	logic [`CHAN_W-1:0] pix_r;
	logic [`CHAN_W-1:0] pix_g;
	logic [`CHAN_W-1:0] pix_b;
	logic frame_end;
	logic [`PIX_CNT_W-1:0] threshold_pixels;
	logic dist_valid;
	logic [`DIST_W-1:0] distance;
	logic mic_valid;
	logic [`MIC_W-1:0] mic_level;
	logic [`MIC_W-1:0] threshold_level;
	robot_nav_pkg::nav_state_t direction;
	logic red_seen;
	logic green_seen;
	logic blue_seen;
	// expected {red, green, blue} flags
	logic [2:0] seen_model;

	robot_nav_top dut0 (
		.clk              (clk),
		.rst              (rst),
		.pix_valid        (pix_valid),
		.pix_r            (pix_r),
		.pix_g            (pix_g),
		.pix_b            (pix_b),
		.frame_end        (frame_end),
		.threshold_pixels (threshold_pixels),
		.dist_valid       (dist_valid),
		.distance         (distance),
		.mic_valid        (mic_valid),
		.mic_level        (mic_level),
		.threshold_level  (threshold_level),
		.direction        (direction),
		.red_seen         (red_seen),
		.green_seen       (green_seen),
		.blue_seen        (blue_seen)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic expect_dir(input robot_nav_pkg::nav_state_t s);
		check("direction", direction, s);
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		pix_valid = 1'b0;
		{pix_r, pix_g, pix_b} = '0;
		frame_end = 1'b0;
		threshold_pixels = `PIX_CNT_W'(PIX_TH);
		dist_valid = 1'b0;
		distance = '0;
		mic_valid = 1'b0;
		mic_level = '0;
		threshold_level = MIC_TH;
		seen_model = '0;
		step(8);
		rst = 1'b0;
	endtask

	// the unique brightest channel wins if it is at or above COLOR_MIN
	function automatic robot_nav_pkg::pixel_color_t classify(input logic [23:0] px);
		int ch [3];
		int top;
		int n_top;
		int which;
		ch[0] = int'(px[23:16]);
		ch[1] = int'(px[15:8]);
		ch[2] = int'(px[7:0]);
		top = 0;
		n_top = 0;
		which = 0;
		for (int i = 0; i < 3; i++) begin
			if (ch[i] > top) begin
				top = ch[i];
				which = i;
			end
		end
		for (int i = 0; i < 3; i++) begin
			if (ch[i] == top) begin
				n_top++;
			end
		end
		if (n_top != 1 || top < `COLOR_MIN) begin
			return robot_nav_pkg::COLOR_NONE;
		end else if (which == 0) begin
			return robot_nav_pkg::COLOR_RED;
		end else if (which == 1) begin
			return robot_nav_pkg::COLOR_GREEN;
		end
		return robot_nav_pkg::COLOR_BLUE;
	endfunction

	// none gives either a dark pixel or a bright red/green tie
	function automatic logic [23:0] make_pixel(input robot_nav_pkg::pixel_color_t c);
		logic [7:0] hi;
		logic [7:0] lo1;
		logic [7:0] lo2;
		hi = 8'($urandom_range(255, `COLOR_MIN));
		lo1 = 8'($urandom_range(int'(hi) - 1, 0));
		lo2 = 8'($urandom_range(int'(hi) - 1, 0));
		case (c)
			robot_nav_pkg::COLOR_RED: return {hi, lo1, lo2};
			robot_nav_pkg::COLOR_GREEN: return {lo1, hi, lo2};
			robot_nav_pkg::COLOR_BLUE: return {lo1, lo2, hi};
			default: begin
				if ($urandom_range(1, 0) == 1) begin
					return {hi, hi, lo1};
				end
				return {8'($urandom_range(`COLOR_MIN - 1, 0)),
					8'($urandom_range(`COLOR_MIN - 1, 0)),
					8'($urandom_range(`COLOR_MIN - 1, 0))};
			end
		endcase
	endfunction

	task automatic send_frame(input int n_r, input int n_g, input int n_b, input int n_dark);
		logic [23:0] pixq [$];
		logic [23:0] px;
		int idx;
		int cnt [4];
		cnt = '{default: 0};
		for (int i = 0; i < n_r + n_g + n_b + n_dark; i++) begin
			if (i < n_r) begin
				pixq.push_back(make_pixel(robot_nav_pkg::COLOR_RED));
			end else if (i < n_r + n_g) begin
				pixq.push_back(make_pixel(robot_nav_pkg::COLOR_GREEN));
			end else if (i < n_r + n_g + n_b) begin
				pixq.push_back(make_pixel(robot_nav_pkg::COLOR_BLUE));
			end else begin
				pixq.push_back(make_pixel(robot_nav_pkg::COLOR_NONE));
			end
		end
		while (pixq.size() > 0) begin
			// idle cycle with a bright pixel on the bus that must not count
			if ($urandom_range(3, 0) == 0) begin
				pix_valid = 1'b0;
				{pix_r, pix_g, pix_b} = make_pixel(robot_nav_pkg::COLOR_BLUE);
				step(1);
			end
			idx = int'($urandom_range(pixq.size() - 1, 0));
			px = pixq[idx];
			pixq.delete(idx);
			cnt[int'(classify(px))]++;
			pix_valid = 1'b1;
			{pix_r, pix_g, pix_b} = px;
			// last pixel goes out together with frame_end
			frame_end = (pixq.size() == 0);
			step(1);
		end
		if (n_r + n_g + n_b + n_dark == 0) begin
			frame_end = 1'b1;
			step(1);
		end
		pix_valid = 1'b0;
		frame_end = 1'b0;
		check("{red,green,blue}_seen early", {red_seen, green_seen, blue_seen}, seen_model);
		seen_model = {cnt[int'(robot_nav_pkg::COLOR_RED)] > PIX_TH,
			cnt[int'(robot_nav_pkg::COLOR_GREEN)] > PIX_TH,
			cnt[int'(robot_nav_pkg::COLOR_BLUE)] > PIX_TH};
		step(1);
		check("{red,green,blue}_seen", {red_seen, green_seen, blue_seen}, seen_model);
	endtask

	task automatic send_distance(input logic [`DIST_W-1:0] d);
		dist_valid = 1'b1;
		distance = d;
		step(1);
		dist_valid = 1'b0;
	endtask

	task automatic send_mic(input logic [`MIC_W-1:0] level);
		mic_valid = 1'b1;
		mic_level = level;
		step(1);
		mic_valid = 1'b0;
	endtask

	// direction moves one cycle after the flags
	task automatic frame_then(input int n_r, input int n_g, input int n_b, input int n_dark,
		input robot_nav_pkg::nav_state_t from, input robot_nav_pkg::nav_state_t to);
		send_frame(n_r, n_g, n_b, n_dark);
		expect_dir(from);
		step(1);
		expect_dir(to);
	endtask

	task automatic loud_to(input robot_nav_pkg::nav_state_t from,
		input robot_nav_pkg::nav_state_t to);
		repeat (`MIC_DEPTH) send_mic(MIC_TH);
		expect_dir(from);
		step(1);
		expect_dir(to);
		// one quiet sample so loud drops again
		send_mic(MIC_TH - 1'b1);
	endtask

	task automatic idle_after_reset();
		reset_dut();
		expect_dir(robot_nav_pkg::IDLE_BASE);
		check("{red,green,blue}_seen", {red_seen, green_seen, blue_seen}, 3'b000);
		frame_then(PIX_TH + 1, 0, 0, 3, robot_nav_pkg::IDLE_BASE, robot_nav_pkg::IDLE_BASE);
		frame_then(0, PIX_TH + 1, PIX_TH + 1, 0, robot_nav_pkg::IDLE_BASE,
			robot_nav_pkg::IDLE_BASE);
		send_distance(`TOO_CLOSE);
		send_distance(`TOO_CLOSE);
		step(2);
		expect_dir(robot_nav_pkg::IDLE_BASE);
	endtask

	task automatic colour_frames();
		reset_dut();
		// counts one below, at and one above the threshold
		for (int i = 0; i < 16; i++) begin
			send_frame(PIX_TH - 1 + int'($urandom_range(2, 0)),
				PIX_TH - 1 + int'($urandom_range(2, 0)),
				PIX_TH - 1 + int'($urandom_range(2, 0)),
				int'($urandom_range(5, 0)));
		end
		expect_dir(robot_nav_pkg::IDLE_BASE);
	endtask

	task automatic mic_window();
		reset_dut();
		repeat (3) send_mic(MIC_TH);
		send_mic(MIC_TH - 1'b1);
		step(2);
		expect_dir(robot_nav_pkg::IDLE_BASE);
		loud_to(robot_nav_pkg::IDLE_BASE, robot_nav_pkg::FORWARDS);
	endtask

	task automatic outbound_trip();
		reset_dut();
		loud_to(robot_nav_pkg::IDLE_BASE, robot_nav_pkg::FORWARDS);
		frame_then(0, 0, PIX_TH + 1, 2, robot_nav_pkg::FORWARDS, robot_nav_pkg::TURN);
		frame_then(0, PIX_TH + 1, 0, 2, robot_nav_pkg::TURN, robot_nav_pkg::TO_TABLE);
		// close while the drive hold still runs
		send_distance(`TOO_CLOSE);
		send_distance(`TOO_CLOSE);
		step(4);
		expect_dir(robot_nav_pkg::TO_TABLE);
		send_distance(`TOO_CLOSE + 1);
		step(`DRIVE_HOLD);
		expect_dir(robot_nav_pkg::TO_TABLE);
		send_distance(`TOO_CLOSE);
		send_distance(`TOO_CLOSE);
		expect_dir(robot_nav_pkg::TO_TABLE);
		step(1);
		expect_dir(robot_nav_pkg::IDLE_TABLE);
	endtask

	task automatic turn_timeout_exit();
		reset_dut();
		loud_to(robot_nav_pkg::IDLE_BASE, robot_nav_pkg::FORWARDS);
		frame_then(0, 0, PIX_TH + 1, 0, robot_nav_pkg::FORWARDS, robot_nav_pkg::TURN);
		step(`TURN_TIMEOUT - 2);
		expect_dir(robot_nav_pkg::TURN);
		step(4);
		expect_dir(robot_nav_pkg::TO_TABLE);
	endtask

	// starts in IDLE_TABLE where outbound_trip stops
	task automatic return_trip();
		send_distance(`TOO_CLOSE + 1);
		send_distance(`TOO_CLOSE + 1);
		frame_then(0, 0, 0, 3, robot_nav_pkg::IDLE_TABLE, robot_nav_pkg::IDLE_TABLE);
		loud_to(robot_nav_pkg::IDLE_TABLE, robot_nav_pkg::BACKWARDS);
		frame_then(0, PIX_TH + 1, 0, 2, robot_nav_pkg::BACKWARDS, robot_nav_pkg::TURN_BACK);
		frame_then(0, 0, PIX_TH + 1, 2, robot_nav_pkg::TURN_BACK, robot_nav_pkg::RETURN_HOME);
		send_distance(`TOO_CLOSE);
		step(2);
		expect_dir(robot_nav_pkg::RETURN_HOME);
		send_distance(`TOO_CLOSE);
		expect_dir(robot_nav_pkg::RETURN_HOME);
		step(1);
		expect_dir(robot_nav_pkg::IDLE_BASE);
	endtask

	// full trip that stops at the table and at home on red frames
	task automatic red_frame_stops();
		reset_dut();
		loud_to(robot_nav_pkg::IDLE_BASE, robot_nav_pkg::FORWARDS);
		frame_then(0, 0, PIX_TH + 1, 0, robot_nav_pkg::FORWARDS, robot_nav_pkg::TURN);
		frame_then(0, PIX_TH + 1, 0, 0, robot_nav_pkg::TURN, robot_nav_pkg::TO_TABLE);
		frame_then(PIX_TH + 1, 0, 0, 0, robot_nav_pkg::TO_TABLE, robot_nav_pkg::IDLE_TABLE);
		frame_then(0, 0, 0, 0, robot_nav_pkg::IDLE_TABLE, robot_nav_pkg::IDLE_TABLE);
		loud_to(robot_nav_pkg::IDLE_TABLE, robot_nav_pkg::BACKWARDS);
		frame_then(0, PIX_TH + 1, 0, 0, robot_nav_pkg::BACKWARDS, robot_nav_pkg::TURN_BACK);
		frame_then(0, 0, PIX_TH + 1, 0, robot_nav_pkg::TURN_BACK, robot_nav_pkg::RETURN_HOME);
		frame_then(PIX_TH + 1, 0, 0, 0, robot_nav_pkg::RETURN_HOME, robot_nav_pkg::IDLE_BASE);
	endtask

	initial begin
		#(RUN_CYCLES * 4);
		$display("timeout: the run did not finish within %0d cycles", RUN_CYCLES);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(32'h38a3));
		reset_dut();
		idle_after_reset();
		colour_frames();
		mic_window();
		outbound_trip();
		return_trip();
		turn_timeout_exit();
		red_frame_stops();
		$display("all tests passed");
		$finish;
	end

endmodule
